/* snappy_fmt_pkg.sv */
/*
  Compressed-format definitions shared by the token parser and the
  history window. Holds the tag kinds taken from the low two bits of a
  tag byte, the copy field types and the limits of the decoded forms.
*/
`default_nettype none

package snappy_fmt_pkg;

	// low two bits of every tag byte
	typedef enum logic [1:0] {
		TAG_LITERAL = 2'b00,
		TAG_COPY1   = 2'b01,
		TAG_COPY2   = 2'b10,
		TAG_COPY4   = 2'b11	// four-byte offset, not decoded here
	} tag_kind_e;

	typedef logic [5:0]  copy_len_t;	// copy length minus one
	typedef logic [15:0] copy_off_t;	// distance back from the write pointer

	// literals longer than this carry extra length bytes
	localparam int LIT_MAX_LEN = 60;

	// copy1 length field sits in tag bits 4:2, biased by this
	localparam int COPY1_LEN_BASE = 4;

endpackage

`default_nettype wire

/* decomp_dp_pkg.sv */
/*
  Datapath types of the decompressor. Bytes, bus words, byte-valid
  masks, lane indexes and the two stream lengths loaded by start.
*/
`default_nettype none

package decomp_dp_pkg;

	localparam int BYTES_PER_WORD = 8;

	typedef logic [7:0]                          byte_t;
	typedef logic [8*BYTES_PER_WORD-1:0]         word_t;	// byte 0 in bits 7:0
	typedef logic [BYTES_PER_WORD-1:0]           bmask_t;
	typedef logic [$clog2(BYTES_PER_WORD)-1:0]   lane_t;	// byte position in a word

	typedef logic [34:0] clen_t;	// compressed length in bytes
	typedef logic [31:0] dlen_t;	// decompressed length in bytes

endpackage

`default_nettype wire

/* data_fifo.sv */
/*
  Input word FIFO. First-word-fall-through read, so dout_o shows the
  head entry whenever empty_o is low. almost_full_o rises once
  FIFO_AF_MARGIN or fewer entries are free, the source stops on it.
*/
`default_nettype none

module data_fifo
	import decomp_dp_pkg::*;
#(
	parameter int FIFO_DEPTH     = 16,
	parameter int FIFO_AF_MARGIN = 4
) (
	input  wire        clk,
	input  wire        arst_n_i,
	input  wire        wr_en_i,
	input  wire word_t din_i,
	input  wire        rd_en_i,
	output word_t      dout_o,
	output logic       empty_o,
	output logic       almost_full_o
);
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	word_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             full;
	logic             do_wr;
	logic             do_rd;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign full          = (count_q == CNT_W'(FIFO_DEPTH));
	assign empty_o       = (count_q == '0);
	assign almost_full_o = (CNT_W'(FIFO_DEPTH) - count_q) <= CNT_W'(FIFO_AF_MARGIN);
	assign do_rd         = rd_en_i && !empty_o;
	assign do_wr         = wr_en_i && (!full || do_rd);
	assign dout_o        = mem[rd_ptr_q];	// head entry falls through

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr_q] <= din_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (do_rd) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({do_wr, do_rd})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// source must have stopped within the almost-full margin
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_en_i |-> (!full || do_rd));

endmodule

`default_nettype wire

/* byte_preparser.sv */
/*
  Splits FIFO words into a byte stream for the token parser. A word is
  pulled when the previous one is used up, bytes go out low lane first,
  and the count loaded by start_i cuts off padding after the last byte.
*/
`default_nettype none

module byte_preparser
	import decomp_dp_pkg::*;
(
	input  wire        clk,
	input  wire        arst_n_i,
	input  wire        start_i,
	input  wire clen_t compression_length_i,
	input  wire        fifo_empty_i,
	input  wire word_t fifo_dout_i,
	output logic       fifo_rd_o,
	input  wire        stall_i,
	input  wire        byte_take_i,
	output byte_t      byte_o,
	output logic       byte_valid_o
);
	word_t word_q;
	lane_t idx_q;
	logic  have_q;	// word_q still holds unread bytes
	clen_t remain_q;
	logic  more;
	logic  take;
	logic  word_end;

	assign more         = (remain_q != '0);
	assign byte_valid_o = have_q && more;
	assign byte_o       = word_q[8*idx_q +: 8];
	assign take         = byte_take_i && byte_valid_o && !stall_i;
	assign fifo_rd_o    = !have_q && more && !fifo_empty_i && !stall_i;

	// last lane, or last byte of the stream
	assign word_end = (idx_q == lane_t'(BYTES_PER_WORD - 1)) || (remain_q == clen_t'(1));

	always_ff @(posedge clk) begin
		if (fifo_rd_o) begin
			word_q <= fifo_dout_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			idx_q    <= '0;
			have_q   <= 1'b0;
			remain_q <= '0;
		end else begin
			if (start_i) begin
				remain_q <= compression_length_i;
			end else if (take) begin
				remain_q <= remain_q - 1'b1;
			end

			if (fifo_rd_o) begin
				have_q <= 1'b1;
				idx_q  <= '0;
			end else if (take) begin
				if (word_end) begin
					have_q <= 1'b0;	// tail past the length is dropped here
					idx_q  <= '0;
				end else begin
					idx_q <= idx_q + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* token_parser.sv */
/*
  Tag decoder. Reads one byte per cycle from the preparser, passes
  literal bytes on to the history window and gathers the offset bytes
  of copy tags into one copy command. Holds while stall_i or busy_i.
*/
`default_nettype none

module token_parser
	import decomp_dp_pkg::*;
	import snappy_fmt_pkg::*;
(
	input  wire        clk,
	input  wire        arst_n_i,
	input  wire        start_i,
	input  wire byte_t byte_i,
	input  wire        byte_valid_i,
	output logic       byte_take_o,
	input  wire        stall_i,
	input  wire        busy_i,
	output logic       lit_valid_o,
	output byte_t      lit_byte_o,
	output logic       copy_valid_o,
	output copy_off_t  copy_off_o,
	output copy_len_t  copy_len_o
);
	typedef enum logic [1:0] {
		ST_TAG,
		ST_LIT,
		ST_OFF_LO,
		ST_OFF_HI
	} parse_state_e;

	parse_state_e state_q;
	tag_kind_e    kind_q;
	tag_kind_e    tag_kind;
	logic [5:0]   lit_left_q;	// literal bytes still to pass, minus one
	copy_len_t    len_q;
	logic [2:0]   off_top_q;	// offset bits 10:8 of a copy1 tag
	byte_t        off_lo_q;
	logic         take;

	assign tag_kind    = tag_kind_e'(byte_i[1:0]);
	assign take        = byte_valid_i && !stall_i && !busy_i;
	assign byte_take_o = take;
	assign lit_valid_o = take && (state_q == ST_LIT);
	assign lit_byte_o  = byte_i;

	// copy1 completes on its only offset byte, copy2 on the high byte
	assign copy_valid_o = take && (state_q == ST_OFF_HI ||
		(state_q == ST_OFF_LO && kind_q == TAG_COPY1));
	assign copy_off_o = (state_q == ST_OFF_HI) ? {byte_i, off_lo_q} :
		{5'b0, off_top_q, byte_i};
	assign copy_len_o = len_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= ST_TAG;
			kind_q     <= TAG_LITERAL;
			lit_left_q <= '0;
		end else if (start_i) begin
			state_q <= ST_TAG;
		end else if (take) begin
			case (state_q)
				ST_TAG: begin
					kind_q <= tag_kind;
					if (tag_kind == TAG_LITERAL) begin
						lit_left_q <= byte_i[7:2];
						state_q    <= ST_LIT;
					end else begin
						state_q <= ST_OFF_LO;
					end
				end
				ST_LIT: begin
					lit_left_q <= lit_left_q - 1'b1;
					if (lit_left_q == '0) begin
						state_q <= ST_TAG;
					end
				end
				ST_OFF_LO: state_q <= (kind_q == TAG_COPY1) ? ST_TAG : ST_OFF_HI;
				ST_OFF_HI: state_q <= ST_TAG;
				default:   state_q <= ST_TAG;
			endcase
		end
	end

	// copy fields from the tag byte
	always_ff @(posedge clk) begin
		if (take && state_q == ST_TAG) begin
			off_top_q <= byte_i[7:5];
			if (tag_kind == TAG_COPY1) begin
				len_q <= copy_len_t'(byte_i[4:2]) + copy_len_t'(COPY1_LEN_BASE - 1);
			end else begin
				len_q <= byte_i[7:2];
			end
		end
		if (take && state_q == ST_OFF_LO) begin
			off_lo_q <= byte_i;
		end
	end

	// stream must stay within the decoded tag forms
	a_tag_supported: assert property (@(posedge clk) disable iff (!arst_n_i)
		(take && state_q == ST_TAG) |-> (tag_kind != TAG_COPY4) &&
		!(tag_kind == TAG_LITERAL && int'(byte_i[7:2]) >= LIT_MAX_LEN));

endmodule

`default_nettype wire

/* history_window.sv */
/*
  History window. Every literal and replayed byte is written into a
  2**HIST_AW byte RAM and forwarded on out_byte_o, one per cycle in
  stream order. A copy reads the RAM one cycle ahead of its replay.
*/
`default_nettype none

module history_window
	import decomp_dp_pkg::*;
	import snappy_fmt_pkg::*;
#(
	parameter int HIST_AW = 12
) (
	input  wire            clk,
	input  wire            arst_n_i,
	input  wire            start_i,
	input  wire            stall_i,
	input  wire            lit_valid_i,
	input  wire byte_t     lit_byte_i,
	input  wire            copy_valid_i,
	input  wire copy_off_t copy_off_i,
	input  wire copy_len_t copy_len_i,
	output logic           busy_o,
	output logic           out_valid_o,
	output byte_t          out_byte_o
);
	byte_t              mem [2**HIST_AW];
	logic [HIST_AW-1:0] wr_ptr_q;
	logic [HIST_AW-1:0] rd_ptr_q;	// address of the next replay read
	logic [HIST_AW-1:0] rd_addr;
	copy_len_t          rep_left_q;	// replay bytes after the current one
	logic               busy_q;
	logic               off_one_q;
	byte_t              rd_data_q;
	byte_t              last_q;	// bypass of the byte just written
	byte_t              new_byte;
	logic               advance;
	logic               produce;
	logic               out_valid_q;
	byte_t              out_byte_q;

	assign advance  = !stall_i;
	assign produce  = advance && (busy_q || lit_valid_i);
	// offset 1 reads the address being written, so take the bypass
	assign new_byte = busy_q ? (off_one_q ? last_q : rd_data_q) : lit_byte_i;
	assign rd_addr  = copy_valid_i ? (wr_ptr_q - copy_off_i[HIST_AW-1:0]) : rd_ptr_q;

	assign busy_o      = busy_q;
	assign out_valid_o = out_valid_q;
	assign out_byte_o  = out_byte_q;

	always_ff @(posedge clk) begin
		if (produce) begin
			mem[wr_ptr_q] <= new_byte;
			last_q        <= new_byte;
			out_byte_q    <= new_byte;
		end
		if (advance) begin
			rd_data_q <= mem[rd_addr];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			rep_left_q  <= '0;
			busy_q      <= 1'b0;
			off_one_q   <= 1'b0;
			out_valid_q <= 1'b0;
		end else if (start_i) begin
			wr_ptr_q <= '0;	// new stream, fresh window
			busy_q   <= 1'b0;
		end else if (advance) begin
			out_valid_q <= produce;
			if (produce) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (copy_valid_i) begin
				busy_q     <= 1'b1;
				rep_left_q <= copy_len_i;
				off_one_q  <= (copy_off_i == copy_off_t'(1));
				rd_ptr_q   <= rd_addr + 1'b1;
			end else if (busy_q) begin
				rd_ptr_q   <= rd_ptr_q + 1'b1;
				rep_left_q <= rep_left_q - 1'b1;
				if (rep_left_q == '0) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	// a copy points into bytes already in the window
	a_copy_off_legal: assert property (@(posedge clk) disable iff (!arst_n_i)
		copy_valid_i |-> (copy_off_i != '0) && (int'(copy_off_i) <= 2**HIST_AW));

endmodule

`default_nettype wire

/* output_packer.sv */
/*
  Output stage. Packs the byte stream into words lane by lane with a
  byte-valid mask. A word closes at eight bytes or at the last byte of
  the stream; it is held until wr_ready_i, and stall_o holds the
  pipeline meanwhile. done_o follows the transfer of the last word.
*/
`default_nettype none

module output_packer
	import decomp_dp_pkg::*;
(
	input  wire        clk,
	input  wire        arst_n_i,
	input  wire        start_i,
	input  wire dlen_t decompression_length_i,
	input  wire        byte_valid_i,
	input  wire byte_t byte_i,
	input  wire        wr_ready_i,
	output logic       stall_o,
	output word_t      data_out_o,
	output bmask_t     byte_valid_out_o,
	output logic       valid_out_o,
	output logic       last_o,
	output logic       done_o
);
	word_t  data_q;
	bmask_t mask_q;
	bmask_t mask_base;
	lane_t  lane_q;
	dlen_t  remain_q;	// stream bytes not yet packed
	logic   valid_q;
	logic   last_q;
	logic   done_q;
	logic   xfer;
	logic   accept;
	logic   close;	// accepted byte ends the word

	assign xfer      = valid_q && wr_ready_i;
	assign stall_o   = valid_q && !wr_ready_i;
	assign accept    = byte_valid_i && !stall_o;
	assign close     = (lane_q == lane_t'(BYTES_PER_WORD - 1)) || (remain_q == dlen_t'(1));
	assign mask_base = xfer ? '0 : mask_q;	// held word leaves this cycle

	assign data_out_o       = data_q;
	assign byte_valid_out_o = mask_q;
	assign valid_out_o      = valid_q;
	assign last_o           = last_q;
	assign done_o           = done_q;

	always_ff @(posedge clk) begin
		if (accept) begin
			data_q[8*lane_q +: 8] <= byte_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mask_q   <= '0;
			lane_q   <= '0;
			remain_q <= '0;
			valid_q  <= 1'b0;
			last_q   <= 1'b0;
			done_q   <= 1'b0;
		end else begin
			done_q <= xfer && last_q;
			if (start_i) begin
				remain_q <= decompression_length_i;
			end
			if (accept) begin
				mask_q   <= mask_base | (bmask_t'(1) << lane_q);
				remain_q <= remain_q - 1'b1;
				if (close) begin
					valid_q <= 1'b1;
					last_q  <= (remain_q == dlen_t'(1));
					lane_q  <= '0;
				end else begin
					lane_q <= lane_q + 1'b1;
					if (xfer) begin
						valid_q <= 1'b0;
						last_q  <= 1'b0;
					end
				end
			end else if (xfer) begin
				valid_q <= 1'b0;
				last_q  <= 1'b0;
				mask_q  <= '0;
			end
		end
	end

	// a word that waits on the sink does not change
	a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
		(valid_out_o && !wr_ready_i) |=> valid_out_o && $stable(data_out_o) &&
		$stable(byte_valid_out_o) && $stable(last_o));

endmodule

`default_nettype wire

/* decompressor.sv */
/*
  Top level of the block decompressor. Input FIFO, byte preparser,
  token parser, history window and output packer in one pipeline.
  Pulse start_i with both lengths, then write compressed words.
*/
`default_nettype none

module decompressor
	import decomp_dp_pkg::*;
	import snappy_fmt_pkg::*;
#(
	parameter int FIFO_DEPTH     = 16,
	parameter int FIFO_AF_MARGIN = 4,
	parameter int HIST_AW        = 12	// window of 4096 bytes
) (
	input  wire         clk,
	input  wire         arst_n_i,
	input  wire word_t  data_i,
	input  wire         valid_in_i,
	input  wire         start_i,
	input  wire clen_t  compression_length_i,	// compressed bytes
	input  wire dlen_t  decompression_length_i,	// plaintext bytes
	input  wire         wr_ready_i,
	output logic        data_fifo_almostfull_o,
	output logic        done_o,
	output logic        last_o,	// final word of the stream
	output word_t       data_out_o,
	output bmask_t      byte_valid_out_o,
	output logic        valid_out_o
);
	word_t     fifo_dout;
	logic      fifo_empty;
	logic      fifo_rd;
	byte_t     pre_byte;
	logic      pre_byte_valid;
	logic      byte_take;
	logic      lit_valid;
	byte_t     lit_byte;
	logic      copy_valid;
	copy_off_t copy_off;
	copy_len_t copy_len;
	logic      win_busy;
	logic      win_out_valid;
	byte_t     win_out_byte;
	logic      stall;	// output word waiting on the sink

	data_fifo #(
		.FIFO_DEPTH    (FIFO_DEPTH),
		.FIFO_AF_MARGIN(FIFO_AF_MARGIN)
	) df0 (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.wr_en_i      (valid_in_i),
		.din_i        (data_i),
		.rd_en_i      (fifo_rd),
		.dout_o       (fifo_dout),
		.empty_o      (fifo_empty),
		.almost_full_o(data_fifo_almostfull_o)
	);

	byte_preparser preparser0 (
		.clk                 (clk),
		.arst_n_i            (arst_n_i),
		.start_i             (start_i),
		.compression_length_i(compression_length_i),
		.fifo_empty_i        (fifo_empty),
		.fifo_dout_i         (fifo_dout),
		.fifo_rd_o           (fifo_rd),
		.stall_i             (stall),
		.byte_take_i         (byte_take),
		.byte_o              (pre_byte),
		.byte_valid_o        (pre_byte_valid)
	);

	token_parser parser0 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.start_i     (start_i),
		.byte_i      (pre_byte),
		.byte_valid_i(pre_byte_valid),
		.byte_take_o (byte_take),
		.stall_i     (stall),
		.busy_i      (win_busy),
		.lit_valid_o (lit_valid),
		.lit_byte_o  (lit_byte),
		.copy_valid_o(copy_valid),
		.copy_off_o  (copy_off),
		.copy_len_o  (copy_len)
	);

	history_window #(
		.HIST_AW(HIST_AW)
	) window0 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.start_i     (start_i),
		.stall_i     (stall),
		.lit_valid_i (lit_valid),
		.lit_byte_i  (lit_byte),
		.copy_valid_i(copy_valid),
		.copy_off_i  (copy_off),
		.copy_len_i  (copy_len),
		.busy_o      (win_busy),
		.out_valid_o (win_out_valid),
		.out_byte_o  (win_out_byte)
	);

	output_packer packer0 (
		.clk                   (clk),
		.arst_n_i              (arst_n_i),
		.start_i               (start_i),
		.decompression_length_i(decompression_length_i),
		.byte_valid_i          (win_out_valid),
		.byte_i                (win_out_byte),
		.wr_ready_i            (wr_ready_i),
		.stall_o               (stall),
		.data_out_o            (data_out_o),
		.byte_valid_out_o      (byte_valid_out_o),
		.valid_out_o           (valid_out_o),
		.last_o                (last_o),
		.done_o                (done_o)
	);

endmodule

`default_nettype wire

/* tb_streams.svh */
/*
  Stream table of the decompressor testbench, included inside its top
  module. load_streams() builds every entry: the compressed bytes, the
  expected plaintext and the sink mode used while the entry runs.
*/
`ifndef TB_STREAMS_SVH
`define TB_STREAMS_SVH

localparam int N_STREAMS    = 4;
localparam int MAX_BYTES    = 512;
localparam int READY_HIGH   = 0;
localparam int READY_RANDOM = 1;
localparam int READY_HELD   = 2;	// low until the input FIFO is almost full

logic [7:0] comp_bytes  [N_STREAMS][MAX_BYTES];
int         comp_len    [N_STREAMS];
logic [7:0] plain_bytes [N_STREAMS][MAX_BYTES];
int         plain_len   [N_STREAMS];
int         ready_mode  [N_STREAMS];
string      test_name   [N_STREAMS];

task automatic put_comp(input int s, input logic [7:0] b);
	comp_bytes[s][comp_len[s]] = b;
	comp_len[s] = comp_len[s] + 1;
endtask

// expected plaintext bytes
task automatic put_text(input int s, input string t);
	for (int i = 0; i < t.len(); i++) begin
		plain_bytes[s][plain_len[s]] = t[i];
		plain_len[s] = plain_len[s] + 1;
	end
endtask

task automatic put_run(input int s, input logic [7:0] c, input int n);
	for (int i = 0; i < n; i++) begin
		plain_bytes[s][plain_len[s]] = c;
		plain_len[s] = plain_len[s] + 1;
	end
endtask

// literal tag holds length minus one in bits 7:2
task automatic put_lit(input int s, input string t);
	put_comp(s, 8'((t.len() - 1) << 2));
	for (int i = 0; i < t.len(); i++) begin
		put_comp(s, t[i]);
	end
	put_text(s, t);
endtask

task automatic put_copy1(input int s, input logic [10:0] off, input int len);
	put_comp(s, {off[10:8], 3'(len - 4), 2'b01});
	put_comp(s, off[7:0]);
endtask

task automatic put_copy2(input int s, input logic [15:0] off, input int len);
	put_comp(s, {6'(len - 1), 2'b10});
	put_comp(s, off[7:0]);	// offset low byte first
	put_comp(s, off[15:8]);
endtask

task automatic load_streams();
	for (int s = 0; s < N_STREAMS; s++) begin
		comp_len[s]  = 0;
		plain_len[s] = 0;
	end

	test_name[0]  = "literal only";
	ready_mode[0] = READY_HIGH;
	put_lit(0, "Hello, world!");

	// offset 1 makes a run, offset 14 goes back to the start
	test_name[1]  = "copy1 runs";
	ready_mode[1] = READY_RANDOM;
	put_lit(1, "abc-");
	put_copy1(1, 11'd1, 10);
	put_run(1, "-", 10);
	put_copy1(1, 11'd14, 4);
	put_text(1, "abc-");
	put_lit(1, "!");

	test_name[2]  = "copy2 far offset";
	ready_mode[2] = READY_RANDOM;
	put_lit(2, "ABCDEFGHZ");
	for (int i = 0; i < 4; i++) begin
		put_copy2(2, 16'd1, 64);
	end
	put_copy2(2, 16'd1, 35);
	put_run(2, "Z", 291);
	put_copy2(2, 16'd300, 8);	// lands on byte 0
	put_text(2, "ABCDEFGH");

	// 159 compressed bytes, 20 input words
	test_name[3]  = "sink held low";
	ready_mode[3] = READY_HELD;
	put_lit(3, "ab");
	for (int i = 0; i < 78; i++) begin
		put_copy1(3, 11'd2, 4);
		put_text(3, "abab");
	end
endtask

`endif

/* tb_decompressor.sv */
/*
  Testbench of the block decompressor. Runs each entry of the stream
  table through the DUT: pulses start, writes the compressed words while
  the FIFO is not almost full, drives wr_ready_i per entry and checks
  every output word, the last flag and the done pulse.
*/
`default_nettype none

module tb_decompressor
	import decomp_dp_pkg::*;
();

	logic   clk;
	logic   arst_n_i;
	word_t  data_i;
	logic   valid_in_i;
	logic   start_i;
	clen_t  compression_length_i;
	dlen_t  decompression_length_i;
	logic   wr_ready_i;
	logic   data_fifo_almostfull_o;
	logic   done_o;
	logic   last_o;
	word_t  data_out_o;
	bmask_t byte_valid_out_o;
	logic   valid_out_o;

	int          errors;
	int          tests_failed;
	int          cycle_cnt;
	int          cycle_limit;
	logic [31:0] rng_state;

	`include "tb_streams.svh"

	decompressor uut (
		.clk                   (clk),
		.arst_n_i              (arst_n_i),
		.data_i                (data_i),
		.valid_in_i            (valid_in_i),
		.start_i               (start_i),
		.compression_length_i  (compression_length_i),
		.decompression_length_i(decompression_length_i),
		.wr_ready_i            (wr_ready_i),
		.data_fifo_almostfull_o(data_fifo_almostfull_o),
		.done_o                (done_o),
		.last_o                (last_o),
		.data_out_o            (data_out_o),
		.byte_valid_out_o      (byte_valid_out_o),
		.valid_out_o           (valid_out_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// watchdog limit comes from the stream lengths
	initial begin
		cycle_cnt = 0;
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles, a stream never finished", cycle_cnt);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input logic failed);
		if (failed) begin
			tests_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic check_idle();
		int err_start;

		err_start = errors;
		expect_bit("valid_out_o", valid_out_o, 1'b0);
		expect_bit("last_o", last_o, 1'b0);
		expect_bit("done_o", done_o, 1'b0);
		expect_bit("data_fifo_almostfull_o", data_fifo_almostfull_o, 1'b0);
		report_test("after reset", errors > err_start);
	endtask

	task automatic run_stream(input int s);
		int     n_words;
		int     wi;
		int     pos;	// plaintext bytes already checked
		int     n_exp;
		int     done_cnt;
		int     tail;
		int     err_start;
		logic   af_seen;
		logic   held;
		logic   done_due;	// last word left at the previous edge
		word_t  held_data;
		bmask_t held_mask;
		logic   held_last;
		word_t  w;
		bmask_t exp_mask;

		n_words   = (comp_len[s] + 7) / 8;
		wi        = 0;
		pos       = 0;
		done_cnt  = 0;
		tail      = 0;
		err_start = errors;
		af_seen   = 1'b0;
		held      = 1'b0;
		done_due  = 1'b0;

		@(negedge clk);
		start_i                = 1'b1;
		compression_length_i   = clen_t'(comp_len[s]);
		decompression_length_i = dlen_t'(plain_len[s]);
		@(negedge clk);
		start_i = 1'b0;

		while (tail < 4) begin
			if (data_fifo_almostfull_o) begin
				af_seen = 1'b1;
			end
			if (wi < n_words && !data_fifo_almostfull_o) begin
				w = '0;	// padding past the stream
				for (int b = 0; b < BYTES_PER_WORD; b++) begin
					if (8 * wi + b < comp_len[s]) begin
						w[8*b +: 8] = comp_bytes[s][8*wi + b];
					end
				end
				data_i     = w;
				valid_in_i = 1'b1;
				wi++;
			end else begin
				valid_in_i = 1'b0;
			end

			rng_state = lcg_next(rng_state);
			case (ready_mode[s])
				READY_RANDOM: wr_ready_i = rng_state[16];
				READY_HELD:   wr_ready_i = af_seen;
				default:      wr_ready_i = 1'b1;
			endcase

			if (held) begin
				assert (valid_out_o && data_out_o == held_data &&
					byte_valid_out_o == held_mask && last_o == held_last) else begin
					$display("CHECK FAILED data_out_o while held: got %h, expected %h",
						data_out_o, held_data);
					errors++;
				end
			end

			// done follows the last transfer by one cycle
			expect_bit("done_o", done_o, done_due);
			done_due = 1'b0;

			// word leaves at the next rising edge
			if (valid_out_o && wr_ready_i) begin
				n_exp = plain_len[s] - pos;
				if (n_exp > BYTES_PER_WORD) begin
					n_exp = BYTES_PER_WORD;
				end
				assert (n_exp > 0) else begin
					$display("output word after the end of stream %0d", s);
					errors++;
				end
				if (n_exp > 0) begin
					exp_mask = bmask_t'((1 << n_exp) - 1);
					assert (byte_valid_out_o == exp_mask) else begin
						$display("CHECK FAILED byte_valid_out_o: got %h, expected %h",
							byte_valid_out_o, exp_mask);
						errors++;
					end
					expect_bit("last_o", last_o, pos + n_exp == plain_len[s]);
					for (int b = 0; b < n_exp; b++) begin
						assert (data_out_o[8*b +: 8] == plain_bytes[s][pos + b]) else begin
							$display("CHECK FAILED data_out_o byte %0d: got %h, expected %h",
								b, data_out_o[8*b +: 8], plain_bytes[s][pos + b]);
							errors++;
						end
					end
					pos      = pos + n_exp;
					done_due = (pos == plain_len[s]);
				end
				held = 1'b0;
			end else begin
				held      = valid_out_o;
				held_data = data_out_o;
				held_mask = byte_valid_out_o;
				held_last = last_o;
			end

			if (done_o) begin
				done_cnt++;
			end
			if (done_cnt > 0) begin
				tail++;	// watch a few cycles for a second pulse
			end
			@(negedge clk);
		end

		assert (pos == plain_len[s]) else begin
			$display("CHECK FAILED output byte count: got %h, expected %h", pos, plain_len[s]);
			errors++;
		end
		assert (done_cnt == 1) else begin
			$display("CHECK FAILED done_o pulses: got %h, expected %h", done_cnt, 1);
			errors++;
		end
		if (ready_mode[s] == READY_HELD) begin
			assert (af_seen) else begin
				$display("data_fifo_almostfull_o never rose while the sink was held");
				errors++;
			end
		end
		report_test(test_name[s], errors > err_start);
	endtask

	initial begin
		int limit;

		errors                 = 0;
		tests_failed           = 0;
		rng_state              = 32'd45;
		arst_n_i               = 1'b0;
		data_i                 = '0;
		valid_in_i             = 1'b0;
		start_i                = 1'b0;
		compression_length_i   = '0;
		decompression_length_i = '0;
		wr_ready_i             = 1'b0;
		load_streams();
		limit = 0;
		for (int s = 0; s < N_STREAMS; s++) begin
			limit = limit + 8 * plain_len[s] + 200;
		end
		cycle_limit = limit;

		repeat (8) @(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);
		check_idle();
		for (int s = 0; s < N_STREAMS; s++) begin
			run_stream(s);
		end

		$display("%0d tests run, %0d failed, %0d check errors",
			N_STREAMS + 1, tests_failed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
snappy_fmt_pkg.sv
decomp_dp_pkg.sv
data_fifo.sv
byte_preparser.sv
token_parser.sv
history_window.sv
output_packer.sv
decompressor.sv
tb_decompressor.sv

/* run_sim.sh */
#!/bin/sh
# Build the decompressor testbench with Verilator, run it, check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_decompressor -f sim.f

status=0
./obj_dir/Vtb_decompressor > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "STATUS: FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
